/* logic/sdram_front_pkg.sv */
`default_nettype none

package sdram_front_pkg;

  localparam int addr_w = 20;  // word address
  localparam int data_w = 16;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [9:0]        burst_len_t;  // controller burst port

  localparam int cache_words_default  = 4;
  localparam int stream_words_default = 16;

  // burst kinds, in the order the arbiter prefers them
  typedef enum logic [1:0] {
    OP_NONE,
    OP_LINE_READ,
    OP_WORD_WRITE,
    OP_LINE_FLUSH
  } op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_TRANSFER,
    ST_RELEASE
  } fsm_state_e;

endpackage

`default_nettype wire

/* logic/burst_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface burst_if;
  import sdram_front_pkg::*;

  op_e        op;          // burst in progress
  logic       start;       // one cycle at issue
  logic       beat;        // wr or rd strobe from controller
  logic [9:0] beat_index;
  logic       last_beat;

  modport arbiter (output op, output start, input beat_index, input last_beat);
  modport counter (input start, input op, input beat, output beat_index, output last_beat);
  modport sink (input op, input start, input beat, input beat_index, input last_beat);

endinterface

`default_nettype wire

/* logic/sdram_arbiter_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module sdram_arbiter_fsm #(
  parameter int cache_words  = sdram_front_pkg::cache_words_default,
  parameter int stream_words = sdram_front_pkg::stream_words_default
) (
  input  logic                        clk,
  input  logic                        sys_rst_n,
  input  logic                        read_req,
  input  logic                        write_req,
  input  logic                        flush_pending,
  input  logic                        read_hit,
  input  sdram_front_pkg::addr_t      address,
  input  sdram_front_pkg::data_t      data_in,
  input  sdram_front_pkg::addr_t      flush_addr,
  input  sdram_front_pkg::data_t      flush_word,
  output logic                        read_ack,
  output logic                        write_ack,
  output logic                        busy,
  output logic                        mem_wr_req,
  output logic                        mem_rd_req,
  output sdram_front_pkg::addr_t      mem_wr_addr,
  output sdram_front_pkg::addr_t      mem_rd_addr,
  output sdram_front_pkg::burst_len_t mem_wr_burst,
  output sdram_front_pkg::burst_len_t mem_rd_burst,
  output sdram_front_pkg::data_t      mem_din,
  burst_if.arbiter                    bus
);
  import sdram_front_pkg::*;

  fsm_state_e state;
  op_e        op;
  op_e        next_op;
  logic       start;
  logic       read_req_q;
  logic       write_req_q;
  logic       read_rise_q;
  logic       rd_pend;
  logic       wr_pend;

  // read miss first, then single write, then flush
  always_comb begin
    if (rd_pend) next_op = OP_LINE_READ;
    else if (wr_pend) next_op = OP_WORD_WRITE;
    else if (flush_pending) next_op = OP_LINE_FLUSH;
    else next_op = OP_NONE;
  end

  assign bus.op    = op;
  assign bus.start = start;
  assign mem_din   = (op == OP_LINE_FLUSH) ? flush_word : data_in;  // taken on each wr beat

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state        <= ST_IDLE;
      op           <= OP_NONE;
      start        <= 1'b0;
      busy         <= 1'b0;
      read_req_q   <= 1'b0;
      write_req_q  <= 1'b0;
      read_rise_q  <= 1'b0;
      rd_pend      <= 1'b0;
      wr_pend      <= 1'b0;
      read_ack     <= 1'b0;
      write_ack    <= 1'b0;
      mem_wr_req   <= 1'b0;
      mem_rd_req   <= 1'b0;
      mem_wr_addr  <= '0;
      mem_rd_addr  <= '0;
      mem_wr_burst <= '0;
      mem_rd_burst <= '0;
    end else begin
      read_req_q  <= read_req;
      write_req_q <= write_req;
      read_rise_q <= read_req && !read_req_q;  // registered edge
      start       <= 1'b0;
      write_ack   <= 1'b0;
      if (read_rise_q) begin
        if (read_hit) read_ack <= 1'b1;  // hit needs no burst
        else rd_pend <= 1'b1;
      end
      if (write_req && !write_req_q) wr_pend <= 1'b1;
      if (!read_req) read_ack <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (next_op != OP_NONE) begin
            state <= ST_REQUEST;
            op    <= next_op;
            start <= 1'b1;
            busy  <= 1'b1;
            case (next_op)
              OP_LINE_READ: begin
                rd_pend      <= 1'b0;
                mem_rd_req   <= 1'b1;
                mem_rd_addr  <= address & ~addr_t'(cache_words - 1);  // line aligned
                mem_rd_burst <= burst_len_t'(cache_words);
              end
              OP_WORD_WRITE: begin
                wr_pend      <= 1'b0;
                mem_wr_req   <= 1'b1;
                mem_wr_addr  <= address;
                mem_wr_burst <= burst_len_t'(1);
              end
              default: begin
                mem_wr_req   <= 1'b1;
                mem_wr_addr  <= flush_addr;
                mem_wr_burst <= burst_len_t'(stream_words);
              end
            endcase
          end
        end
        ST_REQUEST: state <= ST_TRANSFER;
        ST_TRANSFER: begin
          if (bus.last_beat) begin
            state      <= ST_RELEASE;
            mem_wr_req <= 1'b0;  // low the cycle after the last beat
            mem_rd_req <= 1'b0;
            if (op == OP_LINE_READ) read_ack <= 1'b1;
            if (op == OP_WORD_WRITE) write_ack <= 1'b1;
          end
        end
        ST_RELEASE: begin
          state <= ST_IDLE;
          op    <= OP_NONE;
          busy  <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/beat_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module beat_counter #(
  parameter int cache_words  = sdram_front_pkg::cache_words_default,
  parameter int stream_words = sdram_front_pkg::stream_words_default
) (
  input  logic     clk,
  input  logic     sys_rst_n,
  burst_if.counter bus
);
  import sdram_front_pkg::*;

  logic [9:0] beat_index;
  logic [9:0] last_index;

  always_comb begin
    case (bus.op)
      OP_LINE_READ:  last_index = 10'(cache_words - 1);
      OP_LINE_FLUSH: last_index = 10'(stream_words - 1);
      default:       last_index = '0;  // single word
    endcase
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      beat_index <= '0;
    end else if (bus.start) begin
      beat_index <= '0;
    end else if (bus.beat) begin
      beat_index <= beat_index + 10'd1;
    end
  end

  assign bus.beat_index = beat_index;
  assign bus.last_beat  = bus.beat && (bus.op != OP_NONE) && (beat_index == last_index);

endmodule

`default_nettype wire

/* logic/read_line_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module read_line_cache #(
  parameter int cache_words = sdram_front_pkg::cache_words_default
) (
  input  logic                   clk,
  input  logic                   sys_rst_n,
  input  sdram_front_pkg::addr_t address,
  input  sdram_front_pkg::data_t mem_dout,
  input  logic                   write_seen,
  output logic                   read_hit,
  output sdram_front_pkg::data_t data_out,
  burst_if.sink                  bus
);
  import sdram_front_pkg::*;

  localparam int off_w = $clog2(cache_words);

  data_t line [cache_words];
  addr_t tag;  // line base address
  addr_t line_base;
  logic  valid;
  logic  fill_beat;

  assign line_base = address & ~addr_t'(cache_words - 1);
  assign fill_beat = bus.beat && (bus.op == OP_LINE_READ);

  always_ff @(posedge clk) begin
    if (bus.start && bus.op == OP_LINE_READ) tag <= line_base;
    if (fill_beat) line[bus.beat_index[off_w-1:0]] <= mem_dout;
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      valid <= 1'b0;
    end else begin
      if (bus.start && bus.op == OP_LINE_READ) valid <= 1'b0;  // refill under way
      if (fill_beat && bus.last_beat) valid <= 1'b1;
      if (write_seen) valid <= 1'b0;  // any write may hit the line
    end
  end

  assign read_hit = valid && (tag == line_base);
  assign data_out = line[address[off_w-1:0]];

endmodule

`default_nettype wire

/* logic/stream_write_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_write_buffer #(
  parameter int stream_words = sdram_front_pkg::stream_words_default
) (
  input  logic                   clk,
  input  logic                   sys_rst_n,
  input  sdram_front_pkg::addr_t address,
  input  sdram_front_pkg::data_t data_in,
  input  logic                   stream_latch,
  input  logic                   stream_en,
  output sdram_front_pkg::addr_t stream_address,
  output logic                   stream_ready,
  output logic                   flush_pending,
  output sdram_front_pkg::addr_t flush_addr,
  output sdram_front_pkg::data_t flush_word,
  burst_if.sink                  bus
);
  import sdram_front_pkg::*;

  localparam int off_w = $clog2(stream_words);

  data_t front [stream_words];
  data_t back  [stream_words];
  addr_t stream_addr_r;
  addr_t cur_addr;
  logic  line_end;

  assign cur_addr = stream_latch ? address : stream_addr_r;  // latch wins
  assign line_end = &cur_addr[off_w-1:0];

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      stream_addr_r <= '0;
    end else if (stream_en) begin
      stream_addr_r <= cur_addr + addr_t'(1);
    end
  end

  // last word goes straight to the back buffer
  always_ff @(posedge clk) begin
    if (stream_en) begin
      front[cur_addr[off_w-1:0]] <= data_in;
      if (line_end) begin
        for (int i = 0; i < stream_words; i++) begin
          back[i] <= front[i];
        end
        back[stream_words-1] <= data_in;
        flush_addr           <= cur_addr & ~addr_t'(stream_words - 1);
      end
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      flush_pending <= 1'b0;
    end else begin
      if (bus.last_beat && bus.op == OP_LINE_FLUSH) flush_pending <= 1'b0;
      if (stream_en && line_end) flush_pending <= 1'b1;
    end
  end

  assign stream_address = stream_addr_r;
  assign stream_ready   = !(flush_pending && line_end);  // back buffer still busy
  assign flush_word     = back[bus.beat_index[off_w-1:0]];

endmodule

`default_nettype wire

/* logic/sdram_front_end.sv */
`timescale 1ns/100ps
`default_nettype none

module sdram_front_end #(
  parameter int cache_words  = sdram_front_pkg::cache_words_default,
  parameter int stream_words = sdram_front_pkg::stream_words_default
) (
  input  logic                        clk,
  input  logic                        sys_rst_n,
  input  sdram_front_pkg::addr_t      address,
  input  sdram_front_pkg::data_t      data_in,
  output sdram_front_pkg::data_t      data_out,
  input  logic                        read_req,
  output logic                        read_ack,
  input  logic                        write_req,
  output logic                        write_ack,
  input  logic                        stream_latch,
  input  logic                        stream_en,
  output sdram_front_pkg::addr_t      stream_address,
  output logic                        stream_ready,
  output logic                        busy,
  output logic                        mem_wr_req,
  input  logic                        mem_wr_ack,
  output sdram_front_pkg::addr_t      mem_wr_addr,
  output sdram_front_pkg::burst_len_t mem_wr_burst,
  output sdram_front_pkg::data_t      mem_din,
  output logic                        mem_rd_req,
  input  logic                        mem_rd_ack,
  output sdram_front_pkg::addr_t      mem_rd_addr,
  output sdram_front_pkg::burst_len_t mem_rd_burst,
  input  sdram_front_pkg::data_t      mem_dout
);
  import sdram_front_pkg::*;

  logic  read_hit;
  logic  flush_pending;
  logic  write_seen;
  addr_t flush_addr;
  data_t flush_word;

  burst_if bus ();

  assign bus.beat   = mem_wr_ack | mem_rd_ack;  // only one burst runs at a time
  assign write_seen = write_req | stream_en;

  sdram_arbiter_fsm #(
    .cache_words  (cache_words),
    .stream_words (stream_words)
  ) u_arbiter (
    .clk           (clk),
    .sys_rst_n     (sys_rst_n),
    .read_req      (read_req),
    .write_req     (write_req),
    .flush_pending (flush_pending),
    .read_hit      (read_hit),
    .address       (address),
    .data_in       (data_in),
    .flush_addr    (flush_addr),
    .flush_word    (flush_word),
    .read_ack      (read_ack),
    .write_ack     (write_ack),
    .busy          (busy),
    .mem_wr_req    (mem_wr_req),
    .mem_rd_req    (mem_rd_req),
    .mem_wr_addr   (mem_wr_addr),
    .mem_rd_addr   (mem_rd_addr),
    .mem_wr_burst  (mem_wr_burst),
    .mem_rd_burst  (mem_rd_burst),
    .mem_din       (mem_din),
    .bus           (bus.arbiter)
  );

  beat_counter #(
    .cache_words  (cache_words),
    .stream_words (stream_words)
  ) u_counter (
    .clk       (clk),
    .sys_rst_n (sys_rst_n),
    .bus       (bus.counter)
  );

  read_line_cache #(
    .cache_words (cache_words)
  ) u_cache (
    .clk        (clk),
    .sys_rst_n  (sys_rst_n),
    .address    (address),
    .mem_dout   (mem_dout),
    .write_seen (write_seen),
    .read_hit   (read_hit),
    .data_out   (data_out),
    .bus        (bus.sink)
  );

  stream_write_buffer #(
    .stream_words (stream_words)
  ) u_stream (
    .clk            (clk),
    .sys_rst_n      (sys_rst_n),
    .address        (address),
    .data_in        (data_in),
    .stream_latch   (stream_latch),
    .stream_en      (stream_en),
    .stream_address (stream_address),
    .stream_ready   (stream_ready),
    .flush_pending  (flush_pending),
    .flush_addr     (flush_addr),
    .flush_word     (flush_word),
    .bus            (bus.sink)
  );

endmodule

`default_nettype wire

/* verif/sdram_model.sv */
`timescale 1ns/100ps
`default_nettype none

module sdram_model (
  input  logic                        clk,
  input  logic                        sys_rst_n,
  input  logic                        mem_wr_req,
  output logic                        mem_wr_ack,
  input  sdram_front_pkg::addr_t      mem_wr_addr,
  input  sdram_front_pkg::burst_len_t mem_wr_burst,
  input  sdram_front_pkg::data_t      mem_din,
  input  logic                        mem_rd_req,
  output logic                        mem_rd_ack,
  input  sdram_front_pkg::addr_t      mem_rd_addr,
  input  sdram_front_pkg::burst_len_t mem_rd_burst,
  output sdram_front_pkg::data_t      mem_dout
);
  import sdram_front_pkg::*;

  localparam int ack_gap = 3;

  data_t      mem [addr_t];  // sparse, unwritten words read the fill pattern
  logic [1:0] phase;         // 0 idle, 1 gap, 2 beats, 3 wait for drop
  logic       is_rd;
  addr_t      base;
  burst_len_t len;
  burst_len_t sent;
  int         gap;

  function automatic data_t peek(input addr_t a);
    if (mem.exists(a)) return mem[a];
    return data_t'(a[15:0]) ^ {a[19:16], 12'hc35};
  endfunction

  always @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      phase      <= 2'd0;
      is_rd      <= 1'b0;
      base       <= '0;
      len        <= '0;
      sent       <= '0;
      gap        <= 0;
      mem_wr_ack <= 1'b0;
      mem_rd_ack <= 1'b0;
      mem_dout   <= '0;
    end else begin
      mem_wr_ack <= 1'b0;
      mem_rd_ack <= 1'b0;
      if (mem_wr_ack) mem[base + addr_t'(sent) - addr_t'(1)] = mem_din;  // beat taken here
      case (phase)
        2'd0: begin
          if (mem_rd_req || mem_wr_req) begin
            is_rd <= mem_rd_req;
            base  <= mem_rd_req ? mem_rd_addr : mem_wr_addr;
            len   <= mem_rd_req ? mem_rd_burst : mem_wr_burst;
            sent  <= '0;
            gap   <= ack_gap;
            phase <= 2'd1;
          end
        end
        2'd1: begin
          gap <= gap - 1;
          if (gap == 1) phase <= 2'd2;
        end
        2'd2: begin
          if (is_rd) begin
            mem_rd_ack <= 1'b1;
            mem_dout   <= peek(base + addr_t'(sent));
          end else begin
            mem_wr_ack <= 1'b1;
          end
          sent <= sent + 10'd1;
          if (sent + 10'd1 == len) phase <= 2'd3;
        end
        default: begin
          if (!mem_rd_req && !mem_wr_req) phase <= 2'd0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* verif/tb_sdram_front_end.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_sdram_front_end;
  import sdram_front_pkg::*;

  localparam int cache_words  = 4;
  localparam int stream_words = 16;
  localparam int n_ops        = 64;  // directed plus random operations
  localparam int cycle_ns     = 4;

  logic       clk;
  logic       sys_rst_n;
  addr_t      address;
  data_t      data_in;
  data_t      data_out;
  logic       read_req;
  logic       read_ack;
  logic       write_req;
  logic       write_ack;
  logic       stream_latch;
  logic       stream_en;
  addr_t      stream_address;
  logic       stream_ready;
  logic       busy;
  logic       mem_wr_req;
  logic       mem_wr_ack;
  addr_t      mem_wr_addr;
  burst_len_t mem_wr_burst;
  data_t      mem_din;
  logic       mem_rd_req;
  logic       mem_rd_ack;
  addr_t      mem_rd_addr;
  burst_len_t mem_rd_burst;
  data_t      mem_dout;

  int          errors = 0;
  logic [15:0] lfsr = 16'd61;
  string       cur_test = "reset";
  data_t       shadow [addr_t];
  logic        saw_rd_req;
  addr_t       rd_addr_seen;
  burst_len_t  rd_burst_seen;
  int          hit_lat;
  logic        read_ack_q = 1'b0;

  sdram_front_end #(
    .cache_words  (cache_words),
    .stream_words (stream_words)
  ) dut (.*);

  sdram_model mem_model (.*);

  always #2 clk = ~clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic data_t ref_read(input addr_t a);
    if (shadow.exists(a)) return shadow[a];
    return data_t'(a[15:0]) ^ {a[19:16], 12'hc35};  // power-up contents of the model
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_burst(input string name, input burst_len_t exp, input burst_len_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // every rising read_ack is compared with the shadow memory
  always @(posedge clk) begin
    if (read_ack && !read_ack_q) check_data(cur_test, ref_read(address), data_out);
    read_ack_q = read_ack;
  end

  task automatic read_word(input addr_t a);
    int n;
    n = 0;
    @(posedge clk);
    address  <= a;
    read_req <= 1'b1;
    saw_rd_req = 1'b0;
    do begin
      @(posedge clk);
      n++;
      if (mem_rd_req && !saw_rd_req) begin
        saw_rd_req    = 1'b1;
        rd_addr_seen  = mem_rd_addr;
        rd_burst_seen = mem_rd_burst;
      end
    end while (!read_ack);
    hit_lat = n - 1;  // sampled value lags the edge that set it
    read_req <= 1'b0;
    do @(posedge clk); while (read_ack);
  endtask

  task automatic write_word(input addr_t a, input data_t d);
    @(posedge clk);
    address   <= a;
    data_in   <= d;
    write_req <= 1'b1;
    do @(posedge clk); while (!write_ack);
    check_burst({cur_test, " write burst"}, burst_len_t'(1), mem_wr_burst);
    write_req <= 1'b0;
    shadow[a] = d;
  endtask

  task automatic stream_line(input addr_t base);
    data_t d;
    for (int i = 0; i < stream_words; i++) begin
      d = data_t'(rand_bits(16));
      @(posedge clk);
      stream_en    <= 1'b0;
      stream_latch <= (i == 0);
      address      <= base;
      data_in      <= d;
      @(posedge clk);
      while (!stream_ready) @(posedge clk);  // back-pressure
      stream_en <= 1'b1;
      shadow[base + addr_t'(i)] = d;
    end
    @(posedge clk);
    stream_en    <= 1'b0;
    stream_latch <= 1'b0;
    do @(posedge clk); while (!mem_wr_req);
    check_addr({cur_test, " flush addr"}, base, mem_wr_addr);
    check_burst({cur_test, " flush burst"}, burst_len_t'(stream_words), mem_wr_burst);
    check_flag({cur_test, " flush busy"}, 1'b1, busy);
    do @(posedge clk); while (busy);
  endtask

  initial begin
    addr_t      a;
    logic [1:0] kind;
    clk          = 1'b0;
    sys_rst_n    = 1'b0;
    address      = '0;
    data_in      = '0;
    read_req     = 1'b0;
    write_req    = 1'b0;
    stream_latch = 1'b0;
    stream_en    = 1'b0;
    repeat (10) @(posedge clk);
    sys_rst_n <= 1'b1;
    @(posedge clk);
    cur_test = "reset state";
    check_flag("reset read_ack", 1'b0, read_ack);
    check_flag("reset write_ack", 1'b0, write_ack);
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset mem_wr_req", 1'b0, mem_wr_req);
    check_flag("reset mem_rd_req", 1'b0, mem_rd_req);
    check_flag("reset stream_ready", 1'b1, stream_ready);

    cur_test = "write then read";
    write_word(20'h00123, 16'hbeef);
    read_word(20'h00123);
    check_flag("miss rd_req", 1'b1, saw_rd_req);
    check_addr("miss rd addr", 20'h00120, rd_addr_seen);
    check_burst("miss rd burst", burst_len_t'(cache_words), rd_burst_seen);

    cur_test = "read hit";
    read_word(20'h00122);
    check_flag("hit rd_req", 1'b0, saw_rd_req);
    check_data("hit latency", data_t'(2), data_t'(hit_lat));

    cur_test = "stream line";
    stream_line(20'h00400);
    check_addr("stream address", 20'h00410, stream_address);
    for (int i = 0; i < stream_words; i++) read_word(20'h00400 + addr_t'(i));

    cur_test = "write invalidates";
    read_word(20'h00120);
    write_word(20'h00121, 16'h1357);
    read_word(20'h00121);
    check_flag("invalidate rd_req", 1'b1, saw_rd_req);

    cur_test = "random mix";
    for (int k = 0; k < 40; k++) begin
      kind = 2'(rand_bits(2));
      a    = addr_t'(rand_bits(8));
      if (kind == 2'd3) stream_line(a & ~addr_t'(stream_words - 1));
      else if (kind == 2'd2) write_word(a, data_t'(rand_bits(16)));
      else read_word(a);
    end

    repeat (5) @(posedge clk);
    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(n_ops * 200 * cycle_ns + 10 * cycle_ns);
    $display("timeout: run did not finish within %0d cycles", n_ops * 200 + 10);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
logic/sdram_front_pkg.sv
logic/burst_if.sv
logic/sdram_arbiter_fsm.sv
logic/beat_counter.sv
logic/read_line_cache.sv
logic/stream_write_buffer.sv
logic/sdram_front_end.sv
verif/sdram_model.sv
verif/tb_sdram_front_end.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_sdram_front_end
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
